//--- compile.f
logic/tru_pkg.sv
logic/tru_port_timer.sv
logic/tru_table.sv
logic/tru_match.sv
logic/tru_ctrl_fsm.sv
logic/tru_top.sv
sim/tru_tb.sv

//--- logic/tru_ctrl_fsm.sv
`timescale 1ns/1ps

module tru_ctrl_fsm
(
   input  logic                           clk,
   input  logic                           arst_n_i,
   input  logic                           req_valid_i,
   input  logic [tru_pkg::FID_W-1:0]      req_fid_i,
   input  logic [tru_pkg::PORT_ID_W-1:0]  req_port_i,
   input  logic                           resp_ready_i,
   input  logic                           match_drop_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]  match_mask_i,
   output logic                           req_ready_o,
   output logic                           lookup_en_o,
   output logic [tru_pkg::FID_W-1:0]      lookup_fid_o,
   output logic [tru_pkg::PORT_ID_W-1:0]  req_port_o,
   output logic                           resp_valid_o,
   output logic                           resp_drop_o,
   output logic [tru_pkg::NUM_PORTS-1:0]  resp_port_mask_o
);

   tru_pkg::tru_state_e            state_q;
   logic                           rd_wait_q;   // table read in flight
   logic [tru_pkg::FID_W-1:0]      fid_q;
   logic [tru_pkg::PORT_ID_W-1:0]  port_q;
   logic                           drop_q;
   logic [tru_pkg::NUM_PORTS-1:0]  mask_q;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q   <= tru_pkg::ST_IDLE;
         rd_wait_q <= 1'b0;
      end
      else
      begin
         case (state_q)
            tru_pkg::ST_IDLE:
               if (req_valid_i)
                  state_q <= tru_pkg::ST_LOOKUP;
            tru_pkg::ST_LOOKUP:
            begin
               // first cycle issues the read, second waits for the data
               rd_wait_q <= ~rd_wait_q;
               if (rd_wait_q)
                  state_q <= tru_pkg::ST_MATCH;
            end
            tru_pkg::ST_MATCH:
               state_q <= tru_pkg::ST_RESPOND;
            default:
               if (resp_ready_i)
                  state_q <= tru_pkg::ST_IDLE; // held here under back-pressure
         endcase
      end
   end

   // request fields, captured on accept
   always_ff @(posedge clk)
   begin
      if (req_valid_i && req_ready_o)
      begin
         fid_q  <= req_fid_i;
         port_q <= req_port_i;
      end
   end

   // response data, frozen once in ST_RESPOND
   always_ff @(posedge clk)
   begin
      if (state_q == tru_pkg::ST_MATCH)
      begin
         drop_q <= match_drop_i;
         mask_q <= match_mask_i;
      end
   end

   assign req_ready_o      = (state_q == tru_pkg::ST_IDLE);
   assign lookup_en_o      = (state_q == tru_pkg::ST_LOOKUP) && !rd_wait_q;
   assign lookup_fid_o     = fid_q;
   assign req_port_o       = port_q;
   assign resp_valid_o     = (state_q == tru_pkg::ST_RESPOND);
   assign resp_drop_o      = drop_q;
   assign resp_port_mask_o = mask_q;

   // response must not move while the consumer stalls
   resp_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      resp_valid_o && !resp_ready_i |=>
         resp_valid_o && $stable(resp_drop_o) && $stable(resp_port_mask_o));

   // response valid rises on the third edge after accept
   resp_latency_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      req_valid_i && req_ready_o |=> !resp_valid_o [*3] ##1 resp_valid_o);

endmodule

//--- logic/tru_match.sv
`timescale 1ns/1ps

module tru_match
(
   input  logic [tru_pkg::NUM_SUBENTRIES-1:0]                         sub_valid_i,
   input  logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_pattern_mask_i,
   input  logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_pattern_match_i,
   input  tru_pkg::pattern_mode_e [tru_pkg::NUM_SUBENTRIES-1:0]       sub_mode_i,
   input  logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_ports_mask_i,
   input  logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_egress_i,
   input  logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_ingress_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]                              down_pattern_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]                              pass_all_i,
   input  logic [tru_pkg::PORT_ID_W-1:0]                              req_port_i,
   output logic                                                       drop_o,
   output logic [tru_pkg::NUM_PORTS-1:0]                              port_mask_o
);

   logic [tru_pkg::NUM_SUBENTRIES-1:0]  sub_hit;
   logic [tru_pkg::NUM_PORTS-1:0]       egress_acc;
   logic [tru_pkg::NUM_PORTS-1:0]       ingress_acc;

   // which subentries apply to the current down pattern
   always_comb
   begin
      for (int s = 0; s < tru_pkg::NUM_SUBENTRIES; s++)
      begin
         sub_hit[s] = sub_valid_i[s] &&
                      ((down_pattern_i & sub_pattern_mask_i[s]) == sub_pattern_match_i[s]);
      end
   end

   // ascending order, so a later subentry wins in replace mode
   always_comb
   begin
      egress_acc  = '0;
      ingress_acc = '0;
      for (int s = 0; s < tru_pkg::NUM_SUBENTRIES; s++)
      begin
         if (sub_hit[s])
         begin
            if (sub_mode_i[s] == tru_pkg::MODE_REPLACE)
            begin
               egress_acc  = (egress_acc & ~sub_ports_mask_i[s]) |
                             (sub_egress_i[s] & sub_ports_mask_i[s]);
               ingress_acc = (ingress_acc & ~sub_ports_mask_i[s]) |
                             (sub_ingress_i[s] & sub_ports_mask_i[s]);
            end
            else
            begin
               // add mode only sets bits
               egress_acc  = egress_acc | (sub_egress_i[s] & sub_ports_mask_i[s]);
               ingress_acc = ingress_acc | (sub_ingress_i[s] & sub_ports_mask_i[s]);
            end
         end
      end
   end

   // frames from a port not allowed as ingress are dropped
   assign drop_o      = ~ingress_acc[req_port_i];
   assign port_mask_o = drop_o ? '0 : (egress_acc & pass_all_i); // routing unit has final say

endmodule

//--- logic/tru_pkg.sv
package tru_pkg;

   // switch size
   localparam int NUM_PORTS = 8;
   localparam int PORT_ID_W = 3;   // enough to index NUM_PORTS

   // table geometry
   localparam int FID_W          = 2;   // 4 entries
   localparam int NUM_SUBENTRIES = 4;
   localparam int SUB_W          = 2;

   // link must stay up this long before the port is trusted
   localparam int STABLE_UP_CYCLES = 100;
   localparam int STABLE_CNT_W     = 7;  // holds STABLE_UP_CYCLES-1

   // how an applying subentry combines with what came before it
   typedef enum logic
   {
      MODE_REPLACE = 1'b0,  // overwrite bits inside ports mask
      MODE_ADD     = 1'b1   // OR bits inside ports mask
   } pattern_mode_e;

   // request/response FSM
   typedef enum logic [1:0]
   {
      ST_IDLE    = 2'd0,
      ST_LOOKUP  = 2'd1,
      ST_MATCH   = 2'd2,
      ST_RESPOND = 2'd3
   } tru_state_e;

endpackage

//--- logic/tru_port_timer.sv
`timescale 1ns/1ps

module tru_port_timer
(
   input  logic                           clk,
   input  logic                           arst_n_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]  port_up_i,
   output logic [tru_pkg::NUM_PORTS-1:0]  ports_stable_o,
   output logic [tru_pkg::NUM_PORTS-1:0]  down_pattern_o
);

   logic [tru_pkg::STABLE_CNT_W-1:0]  up_cnt_q [tru_pkg::NUM_PORTS];
   logic [tru_pkg::NUM_PORTS-1:0]     stable_q;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < tru_pkg::NUM_PORTS; i++)
         begin
            up_cnt_q[i] <= '0;
         end
         stable_q <= '0;
      end
      else
      begin
         for (int i = 0; i < tru_pkg::NUM_PORTS; i++)
         begin
            if (!port_up_i[i])
            begin
               up_cnt_q[i] <= '0;   // any glitch restarts the count
               stable_q[i] <= 1'b0;
            end
            else if (up_cnt_q[i] ==
                     tru_pkg::STABLE_CNT_W'(tru_pkg::STABLE_UP_CYCLES - 1))
            begin
               stable_q[i] <= 1'b1; // counter saturates here
            end
            else
            begin
               up_cnt_q[i] <= up_cnt_q[i] + 1'b1;
            end
         end
      end
   end

   assign ports_stable_o = stable_q;
   // a port not yet stable is treated as down by the matcher
   assign down_pattern_o = ~stable_q;

   // a stable bit never survives an edge with its link down
   stable_after_down_a: assert property (@(posedge clk) disable iff (!arst_n_i)
      ##1 ((ports_stable_o & ~$past(port_up_i)) == '0));

endmodule

//--- logic/tru_table.sv
`timescale 1ns/1ps

module tru_table
(
   input  logic                                                       clk,
   input  logic                                                       arst_n_i,
   input  logic                                                       cfg_wr_i,
   input  logic                                                       cfg_swap_i,
   input  logic [tru_pkg::FID_W-1:0]                                  cfg_fid_i,
   input  logic [tru_pkg::SUB_W-1:0]                                  cfg_sub_i,
   input  logic                                                       cfg_valid_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]                              cfg_pattern_mask_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]                              cfg_pattern_match_i,
   input  tru_pkg::pattern_mode_e                                     cfg_mode_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]                              cfg_ports_mask_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]                              cfg_egress_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]                              cfg_ingress_i,
   input  logic                                                       lookup_en_i,
   input  logic [tru_pkg::FID_W-1:0]                                  lookup_fid_i,
   output logic [tru_pkg::NUM_SUBENTRIES-1:0]                         sub_valid_o,
   output logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_pattern_mask_o,
   output logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_pattern_match_o,
   output tru_pkg::pattern_mode_e [tru_pkg::NUM_SUBENTRIES-1:0]       sub_mode_o,
   output logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_ports_mask_o,
   output logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_egress_o,
   output logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_ingress_o
);

   // [bank][fid][subentry]
   logic                           valid_mem   [2][2**tru_pkg::FID_W][tru_pkg::NUM_SUBENTRIES];
   logic [tru_pkg::NUM_PORTS-1:0]  pmask_mem   [2][2**tru_pkg::FID_W][tru_pkg::NUM_SUBENTRIES];
   logic [tru_pkg::NUM_PORTS-1:0]  pmatch_mem  [2][2**tru_pkg::FID_W][tru_pkg::NUM_SUBENTRIES];
   tru_pkg::pattern_mode_e         mode_mem    [2][2**tru_pkg::FID_W][tru_pkg::NUM_SUBENTRIES];
   logic [tru_pkg::NUM_PORTS-1:0]  ports_mem   [2][2**tru_pkg::FID_W][tru_pkg::NUM_SUBENTRIES];
   logic [tru_pkg::NUM_PORTS-1:0]  egress_mem  [2][2**tru_pkg::FID_W][tru_pkg::NUM_SUBENTRIES];
   logic [tru_pkg::NUM_PORTS-1:0]  ingress_mem [2][2**tru_pkg::FID_W][tru_pkg::NUM_SUBENTRIES];

   logic active_bank_q;
   logic wr_bank;

   assign wr_bank = ~active_bank_q; // config never touches the bank in use

   // bank select and valid bits
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         active_bank_q <= 1'b0;
         for (int b = 0; b < 2; b++)
            for (int f = 0; f < 2**tru_pkg::FID_W; f++)
               for (int s = 0; s < tru_pkg::NUM_SUBENTRIES; s++)
                  valid_mem[b][f][s] <= 1'b0;
      end
      else
      begin
         if (cfg_swap_i)
            active_bank_q <= ~active_bank_q;
         if (cfg_wr_i)
            valid_mem[wr_bank][cfg_fid_i][cfg_sub_i] <= cfg_valid_i; // old inactive bank on swap
      end
   end

   always_ff @(posedge clk)
   begin
      if (cfg_wr_i)
      begin
         pmask_mem[wr_bank][cfg_fid_i][cfg_sub_i]   <= cfg_pattern_mask_i;
         pmatch_mem[wr_bank][cfg_fid_i][cfg_sub_i]  <= cfg_pattern_match_i;
         mode_mem[wr_bank][cfg_fid_i][cfg_sub_i]    <= cfg_mode_i;
         ports_mem[wr_bank][cfg_fid_i][cfg_sub_i]   <= cfg_ports_mask_i;
         egress_mem[wr_bank][cfg_fid_i][cfg_sub_i]  <= cfg_egress_i;
         ingress_mem[wr_bank][cfg_fid_i][cfg_sub_i] <= cfg_ingress_i;
      end
   end

   // whole entry read at once, held until next lookup
   always_ff @(posedge clk)
   begin
      if (lookup_en_i)
      begin
         for (int s = 0; s < tru_pkg::NUM_SUBENTRIES; s++)
         begin
            sub_valid_o[s]         <= valid_mem[active_bank_q][lookup_fid_i][s];
            sub_pattern_mask_o[s]  <= pmask_mem[active_bank_q][lookup_fid_i][s];
            sub_pattern_match_o[s] <= pmatch_mem[active_bank_q][lookup_fid_i][s];
            sub_mode_o[s]          <= mode_mem[active_bank_q][lookup_fid_i][s];
            sub_ports_mask_o[s]    <= ports_mem[active_bank_q][lookup_fid_i][s];
            sub_egress_o[s]        <= egress_mem[active_bank_q][lookup_fid_i][s];
            sub_ingress_o[s]       <= ingress_mem[active_bank_q][lookup_fid_i][s];
         end
      end
   end

endmodule

//--- logic/tru_top.sv
`timescale 1ns/1ps

module tru_top
(
   input  logic                                clk,
   input  logic                                arst_n_i,
   // forwarding request
   input  logic                                req_valid_i,
   output logic                                req_ready_o,
   input  logic [tru_pkg::FID_W-1:0]           req_fid_i,
   input  logic [tru_pkg::PORT_ID_W-1:0]       req_port_i,
   // forwarding response
   output logic                                resp_valid_o,
   input  logic                                resp_ready_i,
   output logic                                resp_drop_o,
   output logic [tru_pkg::NUM_PORTS-1:0]       resp_port_mask_o,
   // port state and routing enables
   input  logic [tru_pkg::NUM_PORTS-1:0]       port_up_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]       pass_all_i,
   output logic [tru_pkg::NUM_PORTS-1:0]       ports_stable_o,
   // table configuration
   input  logic                                cfg_wr_i,
   input  logic                                cfg_swap_i,
   input  logic [tru_pkg::FID_W-1:0]           cfg_fid_i,
   input  logic [tru_pkg::SUB_W-1:0]           cfg_sub_i,
   input  logic                                cfg_valid_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]       cfg_pattern_mask_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]       cfg_pattern_match_i,
   input  tru_pkg::pattern_mode_e              cfg_mode_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]       cfg_ports_mask_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]       cfg_egress_i,
   input  logic [tru_pkg::NUM_PORTS-1:0]       cfg_ingress_i
);

   logic                                                      lookup_en;
   logic [tru_pkg::FID_W-1:0]                                 lookup_fid;
   logic [tru_pkg::PORT_ID_W-1:0]                             req_port;
   logic [tru_pkg::NUM_PORTS-1:0]                             down_pattern;
   logic                                                      match_drop;
   logic [tru_pkg::NUM_PORTS-1:0]                             match_mask;

   // active bank entry as read out of the table
   logic [tru_pkg::NUM_SUBENTRIES-1:0]                        sub_valid;
   logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_pattern_mask;
   logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_pattern_match;
   tru_pkg::pattern_mode_e [tru_pkg::NUM_SUBENTRIES-1:0]      sub_mode;
   logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_ports_mask;
   logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_egress;
   logic [tru_pkg::NUM_SUBENTRIES-1:0][tru_pkg::NUM_PORTS-1:0] sub_ingress;

   tru_ctrl_fsm u_ctrl_fsm
   (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .req_valid_i      (req_valid_i),
      .req_fid_i        (req_fid_i),
      .req_port_i       (req_port_i),
      .resp_ready_i     (resp_ready_i),
      .match_drop_i     (match_drop),
      .match_mask_i     (match_mask),
      .req_ready_o      (req_ready_o),
      .lookup_en_o      (lookup_en),
      .lookup_fid_o     (lookup_fid),
      .req_port_o       (req_port),
      .resp_valid_o     (resp_valid_o),
      .resp_drop_o      (resp_drop_o),
      .resp_port_mask_o (resp_port_mask_o)
   );

   tru_port_timer u_port_timer
   (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .port_up_i      (port_up_i),
      .ports_stable_o (ports_stable_o),
      .down_pattern_o (down_pattern)
   );

   tru_table u_table
   (
      .clk                 (clk),
      .arst_n_i            (arst_n_i),
      .cfg_wr_i            (cfg_wr_i),
      .cfg_swap_i          (cfg_swap_i),
      .cfg_fid_i           (cfg_fid_i),
      .cfg_sub_i           (cfg_sub_i),
      .cfg_valid_i         (cfg_valid_i),
      .cfg_pattern_mask_i  (cfg_pattern_mask_i),
      .cfg_pattern_match_i (cfg_pattern_match_i),
      .cfg_mode_i          (cfg_mode_i),
      .cfg_ports_mask_i    (cfg_ports_mask_i),
      .cfg_egress_i        (cfg_egress_i),
      .cfg_ingress_i       (cfg_ingress_i),
      .lookup_en_i         (lookup_en),
      .lookup_fid_i        (lookup_fid),
      .sub_valid_o         (sub_valid),
      .sub_pattern_mask_o  (sub_pattern_mask),
      .sub_pattern_match_o (sub_pattern_match),
      .sub_mode_o          (sub_mode),
      .sub_ports_mask_o    (sub_ports_mask),
      .sub_egress_o        (sub_egress),
      .sub_ingress_o       (sub_ingress)
   );

   tru_match u_match
   (
      .sub_valid_i         (sub_valid),
      .sub_pattern_mask_i  (sub_pattern_mask),
      .sub_pattern_match_i (sub_pattern_match),
      .sub_mode_i          (sub_mode),
      .sub_ports_mask_i    (sub_ports_mask),
      .sub_egress_i        (sub_egress),
      .sub_ingress_i       (sub_ingress),
      .down_pattern_i      (down_pattern),
      .pass_all_i          (pass_all_i),
      .req_port_i          (req_port),
      .drop_o              (match_drop),
      .port_mask_o         (match_mask)
   );

endmodule

//--- sim/tru_tb.sv
`timescale 1ns/1ps

module tru_tb;

   logic                                clk;
   logic                                arst_n_i;
   logic                                req_valid_i;
   logic                                req_ready_o;
   logic [tru_pkg::FID_W-1:0]           req_fid_i;
   logic [tru_pkg::PORT_ID_W-1:0]       req_port_i;
   logic                                resp_valid_o;
   logic                                resp_ready_i;
   logic                                resp_drop_o;
   logic [tru_pkg::NUM_PORTS-1:0]       resp_port_mask_o;
   logic [tru_pkg::NUM_PORTS-1:0]       port_up_i;
   logic [tru_pkg::NUM_PORTS-1:0]       pass_all_i;
   logic [tru_pkg::NUM_PORTS-1:0]       ports_stable_o;
   logic                                cfg_wr_i;
   logic                                cfg_swap_i;
   logic [tru_pkg::FID_W-1:0]           cfg_fid_i;
   logic [tru_pkg::SUB_W-1:0]           cfg_sub_i;
   logic                                cfg_valid_i;
   logic [tru_pkg::NUM_PORTS-1:0]       cfg_pattern_mask_i;
   logic [tru_pkg::NUM_PORTS-1:0]       cfg_pattern_match_i;
   tru_pkg::pattern_mode_e              cfg_mode_i;
   logic [tru_pkg::NUM_PORTS-1:0]       cfg_ports_mask_i;
   logic [tru_pkg::NUM_PORTS-1:0]       cfg_egress_i;
   logic [tru_pkg::NUM_PORTS-1:0]       cfg_ingress_i;

   int          checks = 0;
   int          errors = 0;
   int          cycle_cnt = 0;
   int          cycle_limit = 0;
   bit          limit_ready = 1'b0;
   logic [31:0] rng = 32'h5f1e;   // back-pressure seed
   string       lines [$];

   tru_top uut (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // run limit, armed once the data file has been sized
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (limit_ready && cycle_cnt >= cycle_limit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("checks: %0d, errors: %0d", checks, errors);
         $display("Test failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else
      begin
         errors++;
         $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   task automatic write_subentry(input logic [31:0] f [9]);
      cfg_fid_i           = f[0];
      cfg_sub_i           = f[1];
      cfg_valid_i         = f[2];
      cfg_pattern_mask_i  = f[3];
      cfg_pattern_match_i = f[4];
      cfg_mode_i          = tru_pkg::pattern_mode_e'(f[5][0]);
      cfg_ports_mask_i    = f[6];
      cfg_egress_i        = f[7];
      cfg_ingress_i       = f[8];
      cfg_wr_i            = 1'b1;
      @(negedge clk);
      cfg_wr_i = 1'b0;
   endtask

   task automatic swap_bank();
      cfg_swap_i = 1'b1;
      @(negedge clk);
      cfg_swap_i = 1'b0;
   endtask

   task automatic send_request(input string name, input logic [31:0] fid, input logic [31:0] port,
                               input logic [31:0] exp_drop, input logic [31:0] exp_mask);
      int                            lat;
      int                            stall;
      logic                          got_drop;
      logic [tru_pkg::NUM_PORTS-1:0] got_mask;
      rng   = xorshift(rng);
      stall = rng[1:0];   // 0..3 cycles of back-pressure
      req_valid_i = 1'b1;
      req_fid_i   = fid;
      req_port_i  = port;
      while (!req_ready_o)
         @(negedge clk);
      @(negedge clk);   // accept edge has passed
      req_valid_i = 1'b0;
      lat = 0;
      while (!resp_valid_o && lat < 10)
      begin
         @(negedge clk);
         lat++;
      end
      assert (resp_valid_o) else
      begin
         errors++;
         $display("%s: no response came within %0d cycles of the accept", name, lat);
      end
      if (resp_valid_o)
      begin
         check_value({name, " latency"}, 3, lat);
         got_drop = resp_drop_o;
         got_mask = resp_port_mask_o;
         check_value({name, " drop"}, exp_drop, got_drop);
         check_value({name, " mask"}, exp_mask, got_mask);
         repeat (stall)
         begin
            @(negedge clk);
            assert (resp_valid_o && resp_drop_o === got_drop && resp_port_mask_o === got_mask) else
            begin
               errors++;
               $display("%s: response dropped or changed before it was taken", name);
            end
         end
         resp_ready_i = 1'b1;
         @(negedge clk);
         resp_ready_i = 1'b0;
         assert (!resp_valid_o) else
         begin
            errors++;
            $display("%s: response still valid after the transfer", name);
         end
      end
   endtask

   initial
   begin
      int          fd;
      int          n;
      int          wait_sum;
      int          req_cnt;
      string       line;
      string       cmd;
      string       name;
      logic [31:0] fld [9];

      req_valid_i = 1'b0;
      req_fid_i = '0;
      req_port_i = '0;
      resp_ready_i = 1'b0;
      port_up_i = '0;
      pass_all_i = '0;
      cfg_wr_i = 1'b0;
      cfg_swap_i = 1'b0;
      cfg_fid_i = '0;
      cfg_sub_i = '0;
      cfg_valid_i = 1'b0;
      cfg_pattern_mask_i = '0;
      cfg_pattern_match_i = '0;
      cfg_mode_i = tru_pkg::MODE_REPLACE;
      cfg_ports_mask_i = '0;
      cfg_egress_i = '0;
      cfg_ingress_i = '0;
      arst_n_i = 1'b0;
      wait_sum = 0;
      req_cnt = 0;

      // whole file first, so the run limit is known up front
      fd = $fopen("sim/tru_testdata.txt", "r");
      assert (fd != 0) else
      begin
         errors++;
         $display("could not open sim/tru_testdata.txt");
      end
      if (fd != 0)
      begin
         while ($fgets(line, fd))
         begin
            if (line.len() > 1 && line.getc(0) != "#")
            begin
               lines.push_back(line);
               n = $sscanf(line, "%s %d", cmd, fld[0]);
               if (cmd == "D")
                  wait_sum += fld[0];
               else if (cmd == "R")
                  req_cnt++;
            end
         end
         $fclose(fd);
      end
      cycle_limit = wait_sum + 10 * req_cnt + 200;
      limit_ready = 1'b1;

      repeat (10) @(negedge clk);
      arst_n_i = 1'b1;
      check_value("reset resp_valid", 0, resp_valid_o);
      check_value("reset req_ready", 1, req_ready_o);
      check_value("reset ports_stable", 0, ports_stable_o);

      foreach (lines[i])
      begin
         n = $sscanf(lines[i], "%s", cmd);
         case (cmd)
            "W":
            begin
               n = $sscanf(lines[i], "%s %h %h %h %h %h %h %h %h %h", cmd, fld[0], fld[1],
                           fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
               write_subentry(fld);
            end
            "S": swap_bank();
            "P":
            begin
               n = $sscanf(lines[i], "%s %h %h", cmd, fld[0], fld[1]);
               port_up_i  = fld[0];
               pass_all_i = fld[1];
               @(negedge clk);
            end
            "D":
            begin
               n = $sscanf(lines[i], "%s %d", cmd, fld[0]);
               repeat (fld[0]) @(negedge clk);
            end
            "T":
            begin
               n = $sscanf(lines[i], "%s %s %h", cmd, name, fld[0]);
               check_value(name, fld[0], ports_stable_o);
            end
            "R":
            begin
               n = $sscanf(lines[i], "%s %s %h %h %h %h", cmd, name, fld[0], fld[1],
                           fld[2], fld[3]);
               send_request(name, fld[0], fld[1], fld[2], fld[3]);
            end
            default:
            begin
               errors++;
               $display("unknown command in data file: %s", lines[i]);
            end
         endcase
      end

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- sim/tru_testdata.txt
# W fid sub valid pmask pmatch mode ports egress ingress | S | P up pass | D cycles (decimal)
# T name stable | R name fid port drop mask ; all other numbers hex, mode 0 replace 1 add
R reset_drop 0 0 1 00
P ff ff
D 99
T all_up ff
W 1 0 1 00 00 0 ff 0f 0f
W 1 1 1 01 01 0 0f 06 0e
W 1 2 1 02 02 0 0f 0c 0c
W 1 3 1 01 01 1 c0 80 40
S
R base_in 1 2 0 0f
R base_out 1 5 1 00
P fe ff
R down0_p1 1 1 0 86
R down0_p0 1 0 1 00
R add_p6 1 6 0 86
P fc ff
R down01_p2 1 2 0 8c
R down01_p1 1 1 1 00
W 1 0 1 00 00 0 ff f0 ff
R noswap_p2 1 2 0 8c
S
R swap_p2 1 2 0 f0
P fc df
R pass_p2 1 2 0 d0
W 2 0 1 01 00 0 ff 0f ff
W 2 1 1 01 01 0 ff 30 ff
S
R fid2_down 2 3 0 10
P fd df
R fid2_unstable 2 3 0 10
P fc df
P fd df
D 98
T port0_99 fc
D 1
T port0_100 fd
R fid2_stable 2 3 0 0f
R fid1_p2 1 2 0 0c
R fid1_p0 1 0 1 00
